/* design/snac_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants of the SNAC pad reader, imported by every block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package snac_pkg;

    localparam int unsigned CLK_FREQ_HZ = 50_000_000;   // Master clock

    // Polling frequencies, the strobe runs at twice these
    localparam int unsigned FREQ_COMPAT_HZ = 100_000;
    localparam int unsigned FREQ_NORMAL_HZ = 200_000;
    localparam int unsigned FREQ_FAST_HZ   = 400_000;
    localparam int unsigned FREQ_VFAST_HZ  = 1_000_000;

    localparam int unsigned NUM_PADS   = 2;              // Player lanes
    localparam int          NES_BITS   = 8;
    localparam int          SNES_BITS  = 16;
    localparam int          SAMPLE_LAG = 2;              // Cycles from line change to sampling
    localparam logic [1:0]  IDLE_STROBES = 2'd2;         // Quiet strobes between frames

    typedef logic [31:0] phase_t;                        // Accumulator phase and step
    typedef logic [15:0] buttons_t;                      // 1 = pressed
    typedef logic [3:0]  bit_idx_t;                      // Bit slot in a frame

    // step = 2^32 * 2 * f_poll / f_clk, truncated
    localparam phase_t STEP_COMPAT = phase_t'(((64'd1 << 32) * (2 * FREQ_COMPAT_HZ)) / CLK_FREQ_HZ);
    localparam phase_t STEP_NORMAL = phase_t'(((64'd1 << 32) * (2 * FREQ_NORMAL_HZ)) / CLK_FREQ_HZ);
    localparam phase_t STEP_FAST   = phase_t'(((64'd1 << 32) * (2 * FREQ_FAST_HZ)) / CLK_FREQ_HZ);
    localparam phase_t STEP_VFAST  = phase_t'(((64'd1 << 32) * (2 * FREQ_VFAST_HZ)) / CLK_FREQ_HZ);

    typedef enum logic [1:0] {PAD_OFF = 2'd0, PAD_NES = 2'd1, PAD_SNES = 2'd2} pad_type_e;

    typedef enum logic [1:0] {
        RATE_COMPAT = 2'd0,   // 100 kHz
        RATE_NORMAL = 2'd1,   // 200 kHz
        RATE_FAST   = 2'd2,   // 400 kHz
        RATE_VFAST  = 2'd3    // 1 MHz
    } poll_rate_e;

    typedef enum logic [1:0] {IDLE, LATCH, CLK_HIGH, CLK_LOW} seq_state_e;

    typedef struct packed {
        logic clk;   // Shared pad clock
        logic lat;   // Shared latch
    } pad_lines_t;

    typedef struct packed {
        logic     sample;        // Take the data bit now
        logic     frame_start;   // New frame begins
        logic     last;          // This sample closes the frame
        bit_idx_t slot;
    } sample_t;

endpackage

/* design/strobe_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fractional clock enable, one-cycle strobe at the carry of a phase accumulator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module strobe_gen
    import snac_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst,   // Also restarts the phase on a rate change
    input  phase_t i_step,  // Zero stops the strobe
    output logic   o_stb
);

    phase_t phase_q;   // Accumulated phase
    phase_t phase_nx;
    logic   carry;

    // 33-bit add, the carry is the strobe
    assign {carry, phase_nx} = {1'b0, phase_q} + {1'b0, i_step};

    // Strobe in the same cycle as the wrapping add
    assign o_stb = carry;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            phase_q <= '0;   // First strobe a full interval after reset
        end else begin
            phase_q <= phase_nx;
        end
    end

    // Spacing alternates between floor and ceiling of
    // CLK_FREQ_HZ / (2 * f_poll), the truncated step
    // leaves a tiny residue that slowly stretches one interval
    // now and then

endmodule

/* design/latch_sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Drives latch and clock to both pads and tells the lanes when to sample
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module latch_sequencer
    import snac_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_stb,        // Twice the polling frequency
    input  pad_type_e  i_pad_type,
    output pad_lines_t o_lines,      // To the pad pins
    output sample_t    o_sample      // Broadcast to all lanes
);

    seq_state_e state;
    bit_idx_t   slot;                      // Slot of the most recent sample
    bit_idx_t   last_slot;
    logic [1:0] idle_cnt;                  // Quiet strobes left before the next latch
    sample_t    smp_now;                   // Formed together with the line change
    sample_t    smp_pipe [SAMPLE_LAG];     // Lets data pass the pin register first

    assign last_slot = (i_pad_type == PAD_SNES) ? bit_idx_t'(SNES_BITS - 1)
                                                : bit_idx_t'(NES_BITS - 1);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= IDLE;
            slot     <= '0;
            idle_cnt <= '0;   // Latch on the first strobe
            o_lines  <= '0;
            smp_now  <= '0;
        end else begin
            smp_now <= '0;    // One-cycle pulses
            if (i_stb) begin
                case (state)
                    IDLE: begin
                        if (idle_cnt != '0) begin
                            idle_cnt <= idle_cnt - 1'b1;
                        end else if (i_pad_type != PAD_OFF) begin
                            o_lines.lat          <= 1'b1;   // Pads load their buttons
                            smp_now.frame_start  <= 1'b1;
                            state                <= LATCH;
                        end
                    end
                    LATCH: begin
                        o_lines.lat    <= 1'b0;   // Bit 0 now on the data line
                        slot           <= '0;
                        smp_now.sample <= 1'b1;
                        smp_now.slot   <= '0;
                        state          <= CLK_LOW;
                    end
                    CLK_LOW: begin
                        o_lines.clk <= 1'b1;      // Pad shifts to the next bit
                        state       <= CLK_HIGH;
                    end
                    default: begin                // CLK_HIGH
                        o_lines.clk <= 1'b0;
                        if (slot == last_slot) begin
                            idle_cnt <= IDLE_STROBES;   // Trailing pulse done
                            state    <= IDLE;
                        end else begin
                            slot           <= slot + 1'b1;
                            smp_now.sample <= 1'b1;
                            smp_now.slot   <= slot + 1'b1;
                            smp_now.last   <= ((slot + 1'b1) == last_slot);
                            state          <= CLK_LOW;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < SAMPLE_LAG; i++) smp_pipe[i] <= '0;
        end else begin
            smp_pipe[0] <= smp_now;
            for (int i = 1; i < SAMPLE_LAG; i++) smp_pipe[i] <= smp_pipe[i-1];
        end
    end

    assign o_sample = smp_pipe[SAMPLE_LAG-1];

endmodule

/* design/pad_lane.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One player: assembles the serial frame and offers it by req/ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pad_lane
    import snac_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_data,      // Registered pad data, low = pressed
    input  sample_t  i_sample,
    input  logic     i_ack,
    output logic     o_req,
    output buttons_t o_buttons    // Stable while o_req is high
);

    logic filling;    // Current frame accepted
    logic held;       // Word done but previous ack still up
    logic busy_out;   // Word not yet handed over
    logic last_smp;

    assign busy_out = o_req | held;
    assign last_smp = i_sample.sample & i_sample.last & filling;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            filling <= 1'b0;
            held    <= 1'b0;
            o_req   <= 1'b0;
        end else begin
            if (i_sample.frame_start) filling <= !busy_out;   // Drop frame under back-pressure
            else if (last_smp)        filling <= 1'b0;

            if (o_req && i_ack) begin
                o_req <= 1'b0;                  // Collector has the word
            end else if ((last_smp || held) && !i_ack) begin
                o_req <= 1'b1;
                held  <= 1'b0;
            end else if (last_smp) begin
                held  <= 1'b1;                  // Wait for ack to fall
            end
        end
    end

    // NES frames never touch the upper byte, so it stays zero
    always_ff @(posedge i_clk) begin
        if (i_sample.frame_start && !busy_out) o_buttons <= '0;
        else if (i_sample.sample && filling)   o_buttons[i_sample.slot] <= ~i_data;
    end

endmodule

/* design/button_collector.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Takes both lane words in one go and publishes them with a busy flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module button_collector
    import snac_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_frame_start,
    input  logic [NUM_PADS-1:0] i_req,
    input  buttons_t            i_words [NUM_PADS],
    output logic [NUM_PADS-1:0] o_ack,
    output buttons_t            o_p1_buttons,
    output buttons_t            o_p2_buttons,
    output logic                o_busy
);

    logic all_req;
    logic publish;

    assign all_req = &i_req;             // Every lane has a word
    assign publish = &(o_ack & i_req);   // Acks up, words still held

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ack        <= '0;
            o_p1_buttons <= '0;
            o_p2_buttons <= '0;
            o_busy       <= 1'b0;
        end else begin
            // Return phase, per lane
            for (int p = 0; p < NUM_PADS; p++) begin
                if (o_ack[p] && !i_req[p]) o_ack[p] <= 1'b0;
            end
            if (all_req && (o_ack == '0)) o_ack <= '1;

            if (publish) begin
                o_p1_buttons <= i_words[0];
                o_p2_buttons <= i_words[1];
            end

            // Busy spans latch to publication
            if (i_frame_start) o_busy <= 1'b1;
            else if (publish)  o_busy <= 1'b0;
        end
    end

    // Two cycles from both reqs high to new words on the outputs,
    // one to raise ack and one to register with ack seen

endmodule

/* design/snac_reader_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SNAC reader for NES/SNES pads on the cartridge port, configuration A pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module snac_reader_top
    import snac_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  pad_type_e  i_pad_type,
    input  poll_rate_e i_rate,
    input  logic [7:4] i_bk0_in,      // Bit 4 player 1, bit 5 player 2 data
    output logic [7:6] o_bk1_out,     // Bit 6 clk, bit 7 lat
    output buttons_t   o_p1_buttons,
    output buttons_t   o_p2_buttons,
    output logic       o_busy
);

    pad_type_e           pad_type_q;
    poll_rate_e          rate_q;
    logic                blk_rst;        // Reset of every block
    phase_t              step;
    logic                stb;
    pad_lines_t          lines;
    sample_t             sample;
    logic [NUM_PADS-1:0] pad_data_q;     // Pin register
    logic [NUM_PADS-1:0] req;
    logic [NUM_PADS-1:0] ack;
    buttons_t            words [NUM_PADS];

    // Settings and pins, change of type or rate restarts everything
    always_ff @(posedge i_clk) begin
        pad_type_q <= i_pad_type;
        rate_q     <= i_rate;
        blk_rst    <= i_rst || (i_pad_type != pad_type_q) || (i_rate != rate_q);
        pad_data_q <= i_bk0_in[5:4];   // Bits 7:6 unused here
    end

    // Rate table
    always_comb begin
        if (pad_type_q == PAD_OFF) begin
            step = '0;                      // No strobes, lines stay low
        end else begin
            case (rate_q)
                RATE_COMPAT: step = STEP_COMPAT;
                RATE_NORMAL: step = STEP_NORMAL;
                RATE_FAST:   step = STEP_FAST;
                default:     step = STEP_VFAST;
            endcase
        end
    end

    strobe_gen u_strobe_gen (.i_clk(i_clk), .i_rst(blk_rst), .i_step(step), .o_stb(stb));

    latch_sequencer u_latch_sequencer (
        .i_clk      (i_clk),
        .i_rst      (blk_rst),
        .i_stb      (stb),
        .i_pad_type (pad_type_q),
        .o_lines    (lines),
        .o_sample   (sample)
    );

    assign o_bk1_out = {lines.lat, lines.clk};

    for (genvar p = 0; p < NUM_PADS; p++) begin : g_lane
        pad_lane u_pad_lane (
            .i_clk     (i_clk),
            .i_rst     (blk_rst),
            .i_data    (pad_data_q[p]),
            .i_sample  (sample),
            .i_ack     (ack[p]),
            .o_req     (req[p]),
            .o_buttons (words[p])
        );
    end

    button_collector u_button_collector (
        .i_clk         (i_clk),
        .i_rst         (blk_rst),
        .i_frame_start (sample.frame_start),
        .i_req         (req),
        .i_words       (words),
        .o_ack         (ack),
        .o_p1_buttons  (o_p1_buttons),
        .o_p2_buttons  (o_p2_buttons),
        .o_busy        (o_busy)
    );

endmodule

/* testbench/snac_reader_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake and pad line assertions, bound into the collector and the sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module snac_reader_checker
    import snac_pkg::*;
(
    input logic                i_clk,
    input logic                i_rst,     // Unknown before the first settings register load
    input logic [NUM_PADS-1:0] i_req,     // Tied low where only lines are watched
    input logic [NUM_PADS-1:0] i_ack,
    input pad_lines_t          i_lines    // Tied low where only the handshake is watched
);

    int fail_cnt = 0;   // Failed assertions so far

    for (genvar p = 0; p < NUM_PADS; p++) begin : g_hs
        // Ack answers only a full set of requests
        a_ack_needs_req: assert property (@(posedge i_clk) disable iff (i_rst !== 1'b0)
            $rose(i_ack[p]) |-> &i_req)
        else begin
            fail_cnt++;
            $error("ack %0d rose without both requests", p);
        end

        // A request is held until it is answered
        a_req_held: assert property (@(posedge i_clk) disable iff (i_rst !== 1'b0)
            (i_req[p] && !i_ack[p]) |=> i_req[p])
        else begin
            fail_cnt++;
            $error("req %0d dropped before its ack", p);
        end
    end

    a_lines_apart: assert property (@(posedge i_clk) disable iff (i_rst !== 1'b0)
        !(i_lines.clk && i_lines.lat))
    else begin
        fail_cnt++;
        $error("latch and pad clock high together");
    end

endmodule

bind button_collector snac_reader_checker u_collector_checker (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_req   (i_req),
    .i_ack   (o_ack),
    .i_lines ('0)
);

bind latch_sequencer snac_reader_checker u_sequencer_checker (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_req   ('0),
    .i_ack   ('0),
    .i_lines (o_lines)
);

/* testbench/tb_snac_reader.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the SNAC reader, random pad words checked against a pad model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_snac_reader
    import snac_pkg::*;
();

    localparam int MAX_STB_CYC    = (CLK_FREQ_HZ + 2 * FREQ_FAST_HZ - 1) / (2 * FREQ_FAST_HZ);
    localparam int MAX_FRAME_CYC  = 2 * (SNES_BITS + 2) * MAX_STB_CYC;   // Slowest rate used
    localparam int PLANNED_FRAMES = 64;

    logic       clk;
    logic       rst;
    pad_type_e  pad_type;
    poll_rate_e rate;
    logic [7:4] bk0_in;
    logic [7:6] bk1_out;
    buttons_t   p1_buttons;
    buttons_t   p2_buttons;
    logic       busy;

    buttons_t   word_pool [256];        // Random words, drawn once after seeding
    logic [7:0] pool_idx = '0;
    buttons_t   pad_word [2];           // What the pads send in this frame
    int         bit_pos = 16;           // Pad shift position, idle pads read 1
    pad_lines_t lines_q = '0;
    logic       busy_q = 1'b0;
    logic       frame_valid = 1'b0;     // Current frame began under stable settings
    int         settle_cnt = 8;         // Edges ignored while a change settles
    logic       have_edge = 1'b0;
    logic       have_lat = 1'b0;
    int         cyc = 0;
    int         last_edge_cyc = 0;
    int         last_lat_cyc = 0;
    int         frames_done = 0;
    int         chk_cnt = 0;
    int         err_cnt = 0;
    int         asrt_cnt = 0;

    snac_reader_top u_snac_reader_top (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_pad_type   (pad_type),
        .i_rate       (rate),
        .i_bk0_in     (bk0_in),
        .o_bk1_out    (bk1_out),
        .o_p1_buttons (p1_buttons),
        .o_p2_buttons (p2_buttons),
        .o_busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog sized by the longest frame at the slowest rate in use
    initial begin
        repeat (PLANNED_FRAMES * MAX_FRAME_CYC + 20_000) @(posedge clk);
        $display("Watchdog expired before the test sequence finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic int frame_bits(pad_type_e t);
        return (t == PAD_SNES) ? SNES_BITS : ((t == PAD_NES) ? NES_BITS : 0);
    endfunction

    function automatic int poll_hz(poll_rate_e r);
        case (r)
            RATE_COMPAT: return FREQ_COMPAT_HZ;
            RATE_NORMAL: return FREQ_NORMAL_HZ;
            RATE_FAST:   return FREQ_FAST_HZ;
            default:     return FREQ_VFAST_HZ;
        endcase
    endfunction

    task automatic buttons_match(string name, buttons_t got, buttons_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got 0x%04h, expected 0x%04h", name, got, exp);
        end
    endtask

    task automatic lines_match(string name, pad_lines_t got, pad_lines_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got 0x%01h, expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic flag_match(string name, logic got, logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got 0x%01h, expected 0x%01h", name, got, exp);
        end
    endtask

    task automatic span_in_range(string name, int got, int lo, int hi);
        chk_cnt++;
        if (got < lo || got > hi) begin
            err_cnt++;
            $display("[ERROR] %s: got 0x%0h cycles, expected 0x%0h to 0x%0h", name, got, lo, hi);
        end
    endtask

    // Pad model and response monitor, both on the falling edge
    always @(negedge clk) begin
        pad_lines_t now;
        int         lo;
        int         hi;
        int         nstb;
        now  = pad_lines_t'({bk1_out[6], bk1_out[7]});
        lo   = CLK_FREQ_HZ / (2 * poll_hz(rate));                             // Floor
        hi   = (CLK_FREQ_HZ + 2 * poll_hz(rate) - 1) / (2 * poll_hz(rate));   // Ceiling
        nstb = 2 * (frame_bits(pad_type) + 2);                                // Strobes per frame
        cyc++;
        if (now.lat && !lines_q.lat) begin
            pad_word[0] = word_pool[pool_idx];        // Pads load their buttons
            pad_word[1] = word_pool[pool_idx + 8'd1];
            pool_idx    = pool_idx + 8'd2;
            bit_pos     = 0;
        end else if (now.clk && !lines_q.clk) begin
            bit_pos++;                                // Shift on rising pad clock
        end
        for (int p = 0; p < 2; p++) begin
            bk0_in[4+p] = (bit_pos < 16) ? ~pad_word[p][bit_pos] : 1'b1;   // Low = pressed
        end
        if (settle_cnt > 0) begin
            settle_cnt--;
            have_edge   = 1'b0;
            have_lat    = 1'b0;
            frame_valid = 1'b0;
        end else if (now != lines_q) begin
            if (now.lat && !lines_q.lat) begin
                if (have_lat) begin
                    span_in_range("latch spacing", cyc - last_lat_cyc, nstb * lo, nstb * hi);
                end
                last_lat_cyc = cyc;
                have_lat     = 1'b1;
                frame_valid  = 1'b1;
            end else if (have_edge) begin
                span_in_range("strobe interval", cyc - last_edge_cyc, lo, hi);   // One strobe
            end
            last_edge_cyc = cyc;
            have_edge     = 1'b1;
        end
        // Busy falls in the cycle the words are published
        if (busy_q && !busy && frame_valid) begin
            buttons_match("o_p1_buttons", p1_buttons,
                (pad_type == PAD_NES) ? {8'h00, pad_word[0][7:0]} : pad_word[0]);
            buttons_match("o_p2_buttons", p2_buttons,
                (pad_type == PAD_NES) ? {8'h00, pad_word[1][7:0]} : pad_word[1]);
            frames_done++;
        end
        lines_q = now;
        busy_q  = busy;
    end

    task automatic wait_frames(int n);
        int target;
        int waited;
        target = frames_done + n;
        waited = 0;
        while (frames_done < target && waited < (n + 2) * MAX_FRAME_CYC) begin
            @(negedge clk);
            waited++;
        end
        if (frames_done < target) begin
            err_cnt++;
            $display("No published frame seen within %0d cycles", waited);
        end
    endtask

    // New settings, then buttons and busy must be cleared two cycles later
    task automatic apply_config(pad_type_e t, poll_rate_e r);
        @(negedge clk);
        pad_type   = t;
        rate       = r;
        settle_cnt = 4;
        repeat (2) @(posedge clk);
        @(negedge clk);
        buttons_match("o_p1_buttons", p1_buttons, '0);
        buttons_match("o_p2_buttons", p2_buttons, '0);
        flag_match("o_busy", busy, 1'b0);
    endtask

    task automatic await_mid_frame(int clk_rises);
        @(posedge bk1_out[7]);
        repeat (clk_rises) @(posedge bk1_out[6]);
    endtask

    initial begin
        pad_type_e  t;
        poll_rate_e r;
        void'($urandom(32'h4576_ceea));
        foreach (word_pool[i]) word_pool[i] = buttons_t'($urandom);
        rst      = 1'b1;
        pad_type = PAD_SNES;
        rate     = RATE_VFAST;
        bk0_in   = 4'hF;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        wait_frames(4);                      // SNES, fastest rate
        apply_config(PAD_SNES, RATE_FAST);
        wait_frames(3);
        apply_config(PAD_NES, RATE_VFAST);   // Upper byte stays clear
        wait_frames(4);
        apply_config(PAD_NES, RATE_FAST);
        wait_frames(2);

        apply_config(PAD_OFF, RATE_VFAST);
        repeat (300) begin
            @(negedge clk);
            buttons_match("o_p1_buttons", p1_buttons, '0);
            buttons_match("o_p2_buttons", p2_buttons, '0);
            lines_match("o_bk1_out", pad_lines_t'({bk1_out[6], bk1_out[7]}), '0);
            flag_match("o_busy", busy, 1'b0);
        end

        apply_config(PAD_SNES, RATE_VFAST);
        wait_frames(2);
        // Changes in the middle of a frame
        for (int i = 0; i < 6; i++) begin
            t = ($urandom_range(1) != 0) ? PAD_SNES : PAD_NES;
            r = ($urandom_range(1) != 0) ? RATE_FAST : RATE_VFAST;
            if (t == pad_type && r == rate) t = (t == PAD_NES) ? PAD_SNES : PAD_NES;
            await_mid_frame($urandom_range(6, 1));
            apply_config(t, r);
            wait_frames(2);
        end

        asrt_cnt = u_snac_reader_top.u_button_collector.u_collector_checker.fail_cnt
                 + u_snac_reader_top.u_latch_sequencer.u_sequencer_checker.fail_cnt;
        $display("Frames %0d, checks %0d, errors %0d, assertion failures %0d",
                 frames_done, chk_cnt, err_cnt, asrt_cnt);
        if (err_cnt == 0 && asrt_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* snac_reader.f */
design/snac_pkg.sv
design/strobe_gen.sv
design/latch_sequencer.sv
design/pad_lane.sv
design/button_collector.sv
design/snac_reader_top.sv
testbench/snac_reader_checker.sv
testbench/tb_snac_reader.sv
